// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := singleCpuTb
FILELIST  := src.f
OBJDIR    := obj_dir
PASS_MSG  := *** PASSED ***

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  cpuPkg::dataWord a,
    input  cpuPkg::dataWord b,
    input  cpuPkg::aluSel   ctl,
    output cpuPkg::dataWord result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Shift amount

    always_comb begin
        case (ctl)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            // Signed compare
            cpuPkg::aluSlt: result = {31'd0, ($signed(a) < $signed(b))};
            cpuPkg::aluSll: result = a << shamt;
            cpuPkg::aluSrl: result = a >> shamt;    // Logical only
            default:        result = '0;
        endcase
    end

    // Branch compare uses this after a subtract
    assign zero = (result == '0);

endmodule

// ==== design/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  cpuPkg::instWord instr,
    output logic            regWrite,
    output logic            aluSrc,     // 1 selects the immediate
    output logic            memWrite,
    output logic            memToReg,
    output logic            branchEq,
    output logic            branchNe,
    output cpuPkg::aluSel   aluCtl,
    output cpuPkg::immSel   immKind
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];    // Separates sub from add

    always_comb begin
        // Anything not listed below is a no-op
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        branchEq = 1'b0;
        branchNe = 1'b0;
        aluCtl   = cpuPkg::aluAdd;
        immKind  = cpuPkg::immI;

        case (opcode)
            cpuPkg::opReg: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluCtl = funct7b5 ? cpuPkg::aluSub : cpuPkg::aluAdd;
                    3'b001:  aluCtl = cpuPkg::aluSll;
                    3'b010:  aluCtl = cpuPkg::aluSlt;
                    3'b100:  aluCtl = cpuPkg::aluXor;
                    3'b101:  aluCtl = cpuPkg::aluSrl;
                    3'b110:  aluCtl = cpuPkg::aluOr;
                    3'b111:  aluCtl = cpuPkg::aluAnd;
                    default: aluCtl = cpuPkg::aluAdd;
                endcase
            end
            cpuPkg::opImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                // No subtract form here, funct7 is part of the immediate
                case (funct3)
                    3'b010:  aluCtl = cpuPkg::aluSlt;
                    3'b100:  aluCtl = cpuPkg::aluXor;
                    3'b110:  aluCtl = cpuPkg::aluOr;
                    3'b111:  aluCtl = cpuPkg::aluAnd;
                    default: aluCtl = cpuPkg::aluAdd;
                endcase
            end
            cpuPkg::opLoad: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;    // Write back the loaded word
            end
            cpuPkg::opStore: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
                immKind  = cpuPkg::immS;
            end
            cpuPkg::opBranch: begin
                aluCtl   = cpuPkg::aluSub;  // Compare by subtraction
                immKind  = cpuPkg::immB;
                branchEq = (funct3 == 3'b000);
                branchNe = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    // Widths with a meaning of their own
    typedef logic [31:0] dataWord;   // Data or byte address
    typedef logic [31:0] instWord;
    typedef logic [4:0]  regAddr;
    typedef logic [3:0]  aluSel;
    typedef logic [1:0]  immSel;

    // ALU operation codes
    localparam aluSel aluAdd = 4'd0;
    localparam aluSel aluSub = 4'd1;
    localparam aluSel aluAnd = 4'd2;
    localparam aluSel aluOr  = 4'd3;
    localparam aluSel aluXor = 4'd4;
    localparam aluSel aluSlt = 4'd5;
    localparam aluSel aluSll = 4'd6;
    localparam aluSel aluSrl = 4'd7;

    // Immediate formats
    localparam immSel immI = 2'd0;
    localparam immSel immS = 2'd1;
    localparam immSel immB = 2'd2;

    // RV32I major opcodes in the subset
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // Memory depths in words
    localparam int instMemWords = 64;
    localparam int dataMemWords = 64;

    // Word index widths
    localparam int instIdxBits = $clog2(instMemWords);
    localparam int dataIdxBits = $clog2(dataMemWords);

    // Register file
    localparam int regCount = 32;

endpackage

// ==== design/dataMem.sv ====
`timescale 1ns/10ps

module dataMem (
    input  logic            CLK,
    input  logic            rst,
    input  logic            we,
    input  cpuPkg::dataWord addr,   // Byte address, word aligned
    input  cpuPkg::dataWord wd,
    output cpuPkg::dataWord rd
);

    cpuPkg::dataWord mem [cpuPkg::dataMemWords];
    logic [cpuPkg::dataIdxBits-1:0] idx;

    assign idx = addr[cpuPkg::dataIdxBits+1:2];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::dataMemWords; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];   // Combinational read

endmodule

// ==== design/immGen.sv ====
`timescale 1ns/10ps

module immGen (
    input  cpuPkg::instWord instr,
    input  cpuPkg::immSel   immKind,
    output cpuPkg::dataWord imm
);

    logic sign;

    assign sign = instr[31];    // Sign bit sits here in every format

    always_comb begin
        case (immKind)
            cpuPkg::immS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offset, bit 0 always zero
            cpuPkg::immB: imm = {{19{sign}}, instr[31], instr[7],
                                 instr[30:25], instr[11:8], 1'b0};
            default:      imm = {{20{sign}}, instr[31:20]};   // I format
        endcase
    end

endmodule

// ==== design/instMem.sv ====
`timescale 1ns/10ps

module instMem (
    input  logic                             CLK,
    input  logic                             progWe,
    input  logic [cpuPkg::instIdxBits-1:0]   progAddr,  // Word index
    input  cpuPkg::instWord                  progData,
    input  cpuPkg::dataWord                  pc,
    output cpuPkg::instWord                  instr
);

    cpuPkg::instWord mem [cpuPkg::instMemWords];

    // Unwritten words decode as no-ops
    initial begin
        for (int i = 0; i < cpuPkg::instMemWords; i++) begin
            mem[i] = '0;
        end
    end

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Byte address to word index
    assign instr = mem[pc[cpuPkg::instIdxBits+1:2]];

endmodule

// ==== design/pcUnit.sv ====
`timescale 1ns/10ps

module pcUnit (
    input  logic           CLK,
    input  logic           rst,
    input  logic           branchEq,
    input  logic           branchNe,
    input  logic           zero,     // From ALU, operands equal
    input  cpuPkg::dataWord imm,     // B immediate, already shifted
    output cpuPkg::dataWord pc
);

    cpuPkg::dataWord seqPc;
    cpuPkg::dataWord targetPc;
    cpuPkg::dataWord nextPc;
    logic            taken;

    assign seqPc    = pc + 32'd4;
    assign targetPc = pc + imm;

    // beq on equal, bne on not equal
    assign taken = (branchEq && zero) || (branchNe && !zero);

    assign nextPc = taken ? targetPc : seqPc;

    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;    // Core starts at address 0
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic            CLK,
    input  logic            rst,
    input  cpuPkg::regAddr  rs1,
    input  cpuPkg::regAddr  rs2,
    input  cpuPkg::regAddr  rd,
    input  logic            we,
    input  cpuPkg::dataWord wd,
    output cpuPkg::dataWord rd1,
    output cpuPkg::dataWord rd2
);

    cpuPkg::dataWord regs [cpuPkg::regCount];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;     // x0 never written
        end
    end

    // Combinational reads, x0 pinned to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/singleCpu.sv ====
`timescale 1ns/10ps

module singleCpu (
    input  logic                           CLK,
    input  logic                           rst,
    // Program load, used only during reset
    input  logic                           progWe,
    input  logic [cpuPkg::instIdxBits-1:0] progAddr,
    input  cpuPkg::instWord                progData,
    // Retire port
    output logic                           retireValid,
    output cpuPkg::dataWord                retirePc,
    output cpuPkg::instWord                retireInstr,
    output logic                           wbEn,
    output cpuPkg::regAddr                 wbAddr,
    output cpuPkg::dataWord                wbData
);

    cpuPkg::dataWord pc;
    cpuPkg::instWord instr;

    // Decode outputs
    logic            regWrite;
    logic            aluSrc;
    logic            memWrite;
    logic            memToReg;
    logic            branchEq;
    logic            branchNe;
    cpuPkg::aluSel   aluCtl;
    cpuPkg::immSel   immKind;

    // Datapath
    cpuPkg::regAddr  rs1;
    cpuPkg::regAddr  rs2;
    cpuPkg::regAddr  rd;
    cpuPkg::dataWord rd1;
    cpuPkg::dataWord rd2;
    cpuPkg::dataWord imm;
    cpuPkg::dataWord aluB;
    cpuPkg::dataWord aluResult;
    logic            zero;
    cpuPkg::dataWord readData;
    cpuPkg::dataWord wbValue;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    pcUnit uPc (.CLK(CLK), .rst(rst), .branchEq(branchEq), .branchNe(branchNe),
                .zero(zero), .imm(imm), .pc(pc));

    instMem uInstMem (.CLK(CLK), .progWe(progWe), .progAddr(progAddr),
                      .progData(progData), .pc(pc), .instr(instr));

    controlUnit uCtl (.instr(instr), .regWrite(regWrite), .aluSrc(aluSrc),
                      .memWrite(memWrite), .memToReg(memToReg), .branchEq(branchEq),
                      .branchNe(branchNe), .aluCtl(aluCtl), .immKind(immKind));

    regFile uRegs (.CLK(CLK), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
                   .we(wbEn), .wd(wbValue), .rd1(rd1), .rd2(rd2));

    immGen uImm (.instr(instr), .immKind(immKind), .imm(imm));

    assign aluB = aluSrc ? imm : rd2;   // Second operand select

    alu uAlu (.a(rd1), .b(aluB), .ctl(aluCtl), .result(aluResult), .zero(zero));

    dataMem uDataMem (.CLK(CLK), .rst(rst), .we(memWrite), .addr(aluResult),
                      .wd(rd2), .rd(readData));

    assign wbValue = memToReg ? readData : aluResult;

    // One instruction retires every cycle out of reset
    assign retireValid = !rst;
    assign retirePc    = pc;
    assign retireInstr = instr;

    // No write-back to x0 and none during reset
    assign wbEn   = regWrite && (rd != '0) && !rst;
    assign wbAddr = rd;
    assign wbData = wbValue;

endmodule

// ==== src.f ====
design/cpuPkg.sv
design/pcUnit.sv
design/instMem.sv
design/controlUnit.sv
design/regFile.sv
design/immGen.sv
design/alu.sv
design/dataMem.sv
design/singleCpu.sv
testbench/singleCpu_sva.sv
testbench/singleCpuTb.sv

// ==== testbench/singleCpuTb.sv ====
`timescale 1ns/10ps

module singleCpuTb;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 2;     // Reset kept this long after the load
    localparam int numRows     = 22;
    // Load, reset, execution, plus margin
    localparam int timeoutCycles = numRows + resetCycles + numRows + 10;

    typedef logic [cpuPkg::instIdxBits-1:0] progIdx;

    // One program word and what it should retire with
    typedef struct packed {
        cpuPkg::instWord instr;
        logic            executed;
        logic            wbEn;
        cpuPkg::regAddr  wbAddr;
        cpuPkg::dataWord wbData;
    } progRow;

    logic            CLK;
    logic            rst;
    logic            progWe;
    progIdx          progAddr;
    cpuPkg::instWord progData;
    logic            retireValid;
    cpuPkg::dataWord retirePc;
    cpuPkg::instWord retireInstr;
    logic            wbEn;
    cpuPkg::regAddr  wbAddr;
    cpuPkg::dataWord wbData;

    progRow rows [numRows];

    singleCpu uut (
        .CLK(CLK),
        .rst(rst),
        .progWe(progWe),
        .progAddr(progAddr),
        .progData(progData),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireInstr(retireInstr),
        .wbEn(wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData)
    );

    initial begin
        CLK = 1'b0;
        forever #(clkPeriod / 2) CLK = ~CLK;
    end

    // Instruction encoders
    function automatic cpuPkg::instWord rType(input logic [6:0] funct7,
            input cpuPkg::regAddr rs2, input cpuPkg::regAddr rs1,
            input logic [2:0] funct3, input cpuPkg::regAddr rd);
        return {funct7, rs2, rs1, funct3, rd, cpuPkg::opReg};
    endfunction

    function automatic cpuPkg::instWord iType(input logic [6:0] opcode,
            input logic [11:0] imm, input cpuPkg::regAddr rs1,
            input logic [2:0] funct3, input cpuPkg::regAddr rd);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic cpuPkg::instWord sType(input logic [11:0] imm,
            input cpuPkg::regAddr rs2, input cpuPkg::regAddr rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpuPkg::opStore};
    endfunction

    function automatic cpuPkg::instWord bType(input logic [12:0] offset,
            input cpuPkg::regAddr rs2, input cpuPkg::regAddr rs1, input logic [2:0] funct3);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
                cpuPkg::opBranch};
    endfunction

    function automatic progRow makeRow(input cpuPkg::instWord instr, input logic executed,
            input logic wbEn, input cpuPkg::regAddr wbAddr, input cpuPkg::dataWord wbData);
        return '{instr, executed, wbEn, wbAddr, wbData};
    endfunction

    task automatic buildTable();
        // Immediate arithmetic
        rows[0]  = makeRow(iType(cpuPkg::opImm, 12'd5, 5'd0, 3'b000, 5'd1),
                           1'b1, 1'b1, 5'd1, 32'h0000_0005);    // addi x1, x0, 5
        rows[1]  = makeRow(iType(cpuPkg::opImm, 12'hFFD, 5'd0, 3'b000, 5'd2),
                           1'b1, 1'b1, 5'd2, 32'hFFFF_FFFD);    // addi x2, x0, -3
        rows[2]  = makeRow(iType(cpuPkg::opImm, 12'd6, 5'd1, 3'b111, 5'd3),
                           1'b1, 1'b1, 5'd3, 32'h0000_0004);    // andi, 5 & 6
        rows[3]  = makeRow(iType(cpuPkg::opImm, 12'd8, 5'd1, 3'b110, 5'd4),
                           1'b1, 1'b1, 5'd4, 32'h0000_000D);    // ori, 5 | 8
        rows[4]  = makeRow(iType(cpuPkg::opImm, 12'd3, 5'd1, 3'b100, 5'd5),
                           1'b1, 1'b1, 5'd5, 32'h0000_0006);    // xori, 5 ^ 3
        rows[5]  = makeRow(iType(cpuPkg::opImm, 12'd1, 5'd2, 3'b010, 5'd6),
                           1'b1, 1'b1, 5'd6, 32'h0000_0001);    // slti, -3 < 1
        rows[6]  = makeRow(iType(cpuPkg::opImm, 12'hFFF, 5'd1, 3'b010, 5'd7),
                           1'b1, 1'b1, 5'd7, 32'h0000_0000);    // slti, 5 < -1 false
        // Register arithmetic on earlier results
        rows[7]  = makeRow(rType(7'h00, 5'd4, 5'd1, 3'b000, 5'd8),
                           1'b1, 1'b1, 5'd8, 32'h0000_0012);    // add, 5 + 13
        rows[8]  = makeRow(rType(7'h20, 5'd4, 5'd1, 3'b000, 5'd9),
                           1'b1, 1'b1, 5'd9, 32'hFFFF_FFF8);    // sub, 5 - 13
        rows[9]  = makeRow(rType(7'h00, 5'd5, 5'd4, 3'b111, 5'd10),
                           1'b1, 1'b1, 5'd10, 32'h0000_0004);   // and, 13 & 6
        rows[10] = makeRow(rType(7'h00, 5'd5, 5'd3, 3'b110, 5'd11),
                           1'b1, 1'b1, 5'd11, 32'h0000_0006);   // or, 4 | 6
        rows[11] = makeRow(rType(7'h00, 5'd5, 5'd4, 3'b100, 5'd12),
                           1'b1, 1'b1, 5'd12, 32'h0000_000B);   // xor, 13 ^ 6
        rows[12] = makeRow(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd13),
                           1'b1, 1'b1, 5'd13, 32'h0000_0001);   // slt, -3 < 5
        rows[13] = makeRow(rType(7'h00, 5'd3, 5'd1, 3'b001, 5'd14),
                           1'b1, 1'b1, 5'd14, 32'h0000_0050);   // sll, 5 << 4
        rows[14] = makeRow(rType(7'h00, 5'd3, 5'd9, 3'b101, 5'd15),
                           1'b1, 1'b1, 5'd15, 32'h0FFF_FFFF);   // srl, no sign fill
        // Store then load back
        rows[15] = makeRow(sType(12'd8, 5'd8, 5'd0), 1'b1, 1'b0, 5'd0, 32'h0);
        rows[16] = makeRow(iType(cpuPkg::opLoad, 12'd8, 5'd0, 3'b010, 5'd16),
                           1'b1, 1'b1, 5'd16, 32'h0000_0012);   // lw x16, 8(x0)
        // Taken beq jumps over row 18
        rows[17] = makeRow(bType(13'd8, 5'd1, 5'd1, 3'b000), 1'b1, 1'b0, 5'd0, 32'h0);
        rows[18] = makeRow(iType(cpuPkg::opImm, 12'd1, 5'd0, 3'b000, 5'd17),
                           1'b0, 1'b0, 5'd0, 32'h0);
        rows[19] = makeRow(bType(13'd8, 5'd1, 5'd1, 3'b001), 1'b1, 1'b0, 5'd0, 32'h0);
        // x0 destination and source
        rows[20] = makeRow(iType(cpuPkg::opImm, 12'd7, 5'd1, 3'b000, 5'd0),
                           1'b1, 1'b0, 5'd0, 32'h0);
        rows[21] = makeRow(rType(7'h00, 5'd16, 5'd0, 3'b000, 5'd18),
                           1'b1, 1'b1, 5'd18, 32'h0000_0012);   // add x18, x0, x16
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compareSignal(input string name, input logic [31:0] actual,
            input logic [31:0] expected);
        assert (actual === expected)
        else abortRun($sformatf("Error: %s = 0x%h, expected 0x%h", name, actual, expected));
    endtask

    task automatic checkRetire(input int idx);
        progRow exp;
        exp = rows[idx];
        compareSignal("retireValid", 32'(retireValid), 32'h1);
        compareSignal("retirePc", retirePc, cpuPkg::dataWord'(idx * 4));
        compareSignal("retireInstr", retireInstr, exp.instr);
        compareSignal("wbEn", 32'(wbEn), 32'(exp.wbEn));
        if (exp.wbEn) begin
            compareSignal("wbAddr", 32'(wbAddr), 32'(exp.wbAddr));
            compareSignal("wbData", wbData, exp.wbData);
        end
    endtask

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        abortRun($sformatf("Timeout: the run did not finish within %0d clock cycles",
                           timeoutCycles));
    end

    initial begin
        rst      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildTable();

        // Program load while the core sits in reset
        for (int i = 0; i < numRows; i++) begin
            @(posedge CLK);
            progWe   <= 1'b1;
            progAddr <= progIdx'(i);
            progData <= rows[i].instr;
        end
        @(posedge CLK);
        progWe <= 1'b0;

        repeat (resetCycles) begin
            @(negedge CLK);
            compareSignal("retireValid", 32'(retireValid), 32'h0);
            compareSignal("wbEn", 32'(wbEn), 32'h0);
        end
        @(posedge CLK);
        rst <= 1'b0;

        // Rows in pc order, a skipped row takes no cycle
        for (int i = 0; i < numRows; i++) begin
            if (rows[i].executed) begin
                @(negedge CLK);     // Mid-cycle, retire port settled
                checkRetire(i);
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== testbench/singleCpu_sva.sv ====
`timescale 1ns/10ps

module singleCpuSva (
    input  logic            CLK,
    input  logic            rst,
    input  logic            retireValid,
    input  cpuPkg::dataWord retirePc,
    input  cpuPkg::instWord retireInstr,
    input  logic            wbEn,
    input  cpuPkg::regAddr  wbAddr
);

    logic isBranch;

    assign isBranch = (retireInstr[6:0] == cpuPkg::opBranch);

    // Nothing retires while the core is held in reset
    noRetireInReset: assert property (@(posedge CLK) rst |-> !retireValid)
        else $error("retireValid is high while rst is asserted");

    noWriteToX0: assert property (@(posedge CLK) !(wbEn && (wbAddr == '0)))
        else $error("wbEn is high with wbAddr pointing at x0");

    // Straight-line code steps one word
    seqPcStep: assert property (
        @(posedge CLK) (!rst && !isBranch) |=> (retirePc == $past(retirePc) + 32'd4))
        else $error("retirePc did not advance by 4 after a non-branch instruction");

endmodule

bind singleCpu singleCpuSva uSva (
    .CLK(CLK),
    .rst(rst),
    .retireValid(retireValid),
    .retirePc(retirePc),
    .retireInstr(retireInstr),
    .wbEn(wbEn),
    .wbAddr(wbAddr)
);
